// File: all.f
+incdir+include
hw/stk_cfg_pkg.sv
hw/stk_cmd_pkg.sv
hw/stk_slot_alloc.sv
hw/stk_ctx_table.sv
hw/stk_lookup.sv
hw/stk_data_ram.sv
hw/stk_rsp_queue.sv
hw/stk_engine.sv
tb/tb_stk_engine.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the stack engine testbench with Verilator
# The log is searched for the failure line to decide the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_stk_engine \
  -Mdir obj_dir -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: tb/tb_stk_engine.sv
/*
 * Testbench for the stack engine
 *   clock, reset, credit-limited command driver
 *   LFSR stimulus, per-context stack model, expected response queue
 *   response, latency, back-pressure and credit checks
 *   cycle-count timeout
 */
`timescale 1ns/1ps

`include "stk_consts.svh"

module tb_stk_engine
  import stk_cfg_pkg::*;
  import stk_cmd_pkg::*;
();

  localparam int RAND_CMDS      = 200;
  localparam int DIRECTED_CMDS  = 64;
  // About 20 cycles per command plus reset and drain slack
  localparam int TIMEOUT_CYCLES = 20 * (RAND_CMDS + DIRECTED_CMDS) + 100;

  // One predicted response
  typedef struct packed {
    engid_t  engid;
    opcode_e opcode;
    status_e status;
    data_t   data;
  } rsp_t;

  logic    clk;
  logic    i_rst_n;
  logic    i_cmd_vld;
  engid_t  i_cmd_engid;
  opcode_e i_cmd_opcode;
  data_t   i_cmd_data;
  logic    i_rsp_rdy;
  logic    o_cmd_credit;
  logic    o_rsp_vld;
  engid_t  o_rsp_engid;
  opcode_e o_rsp_opcode;
  status_e o_rsp_status;
  data_t   o_rsp_data;

  // Model stacks per context with the top at the back
  data_t model_stk [`STK_ENGS_N][$];
  int    slots_used = 0;
  rsp_t  exp_q [$];
  // Commands sent and credits returned
  int    sent       = 0;
  int    returned   = 0;
  int    cyc        = 0;
  logic [15:0] lfsr_q = 16'd12;

  stk_engine UUT (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_vld    (i_cmd_vld),
    .i_cmd_engid  (i_cmd_engid),
    .i_cmd_opcode (i_cmd_opcode),
    .i_cmd_data   (i_cmd_data),
    .o_cmd_credit (o_cmd_credit),
    .o_rsp_vld    (o_rsp_vld),
    .o_rsp_engid  (o_rsp_engid),
    .o_rsp_opcode (o_rsp_opcode),
    .o_rsp_status (o_rsp_status),
    .o_rsp_data   (o_rsp_data),
    .i_rsp_rdy    (i_rsp_rdy)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
    abort_run();
  endtask

  task automatic fail_text(input string why);
    $display("t=%0t %s", $time, why);
    abort_run();
  endtask

  // Fibonacci LFSR with taps 16 14 13 11
  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int credits_left();
    return `STK_CREDITS_N - (sent - returned);
  endfunction

  // Expected response from the stack rules
  // Model is updated at send time
  function automatic rsp_t predict(input opcode_e op, input engid_t eng, input data_t d);
    rsp_t r;
    r.engid  = eng;
    r.opcode = op;
    r.status = ST_OKAY;
    r.data   = '0;
    if (op == OP_POP) begin
      if (model_stk[eng].size() == 0) begin
        r.status = ST_ERR_EMPTY;
      end else begin
        r.data = model_stk[eng].pop_back();
        slots_used--;
      end
    end else if (slots_used == `STK_SLOTS_N) begin
      r.status = ST_ERR_FULL;
    end else begin
      model_stk[eng].push_back(d);
      slots_used++;
    end
    return r;
  endfunction

  // Drive at the current edge
  // Caller holds a credit
  task automatic drive_cmd(input opcode_e op, input engid_t eng, input data_t d);
    i_cmd_vld    <= 1'b1;
    i_cmd_opcode <= op;
    i_cmd_engid  <= eng;
    i_cmd_data   <= d;
    exp_q.push_back(predict(op, eng, d));
    sent++;
  endtask

  // Next edge or later if no credit is held
  task automatic send_cmd(input opcode_e op, input engid_t eng, input data_t d);
    @(posedge clk);
    while (credits_left() == 0) begin
      i_cmd_vld <= 1'b0;
      @(posedge clk);
    end
    drive_cmd(op, eng, d);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      i_cmd_vld <= 1'b0;
    end
  endtask

  // Until every predicted response has been taken
  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      i_cmd_vld <= 1'b0;
    end
  endtask

  task automatic pop_all(input engid_t eng);
    int n;
    n = model_stk[eng].size();
    repeat (n) send_cmd(OP_POP, eng, '0);
  endtask

  // Idle engine with ready high
  // Response must show in the third cycle
  task automatic check_latency(input opcode_e op, input engid_t eng, input data_t d);
    int waited;
    waited = 0;
    send_cmd(op, eng, d);
    do begin
      @(posedge clk);
      i_cmd_vld <= 1'b0;
      @(negedge clk);
      waited++;
    end while (!o_rsp_vld && waited < 8);
    assert (waited == 3) else fail_value("o_rsp_vld latency", 32'(waited), 32'd3);
  endtask

  // Held response keeps its fields until taken
  hold_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_rsp_vld && !i_rsp_rdy) |=> (o_rsp_vld && $stable(o_rsp_data)
      && $stable(o_rsp_engid) && $stable(o_rsp_opcode) && $stable(o_rsp_status)))
    else fail_text("response changed or dropped while held under back-pressure");

  // Outputs are steady at the falling edge
  always @(negedge clk) begin
    rsp_t exp_r;
    if (i_rst_n) begin
      assert (o_cmd_credit == (o_rsp_vld && i_rsp_rdy))
        else fail_value("o_cmd_credit", 32'(o_cmd_credit), 32'(o_rsp_vld && i_rsp_rdy));
      if (o_cmd_credit) begin
        returned++;
      end
      if (o_rsp_vld && i_rsp_rdy) begin
        assert (exp_q.size() != 0) else fail_text("response with no command outstanding");
        exp_r = exp_q.pop_front();
        assert (o_rsp_engid == exp_r.engid)
          else fail_value("o_rsp_engid", 32'(o_rsp_engid), 32'(exp_r.engid));
        assert (o_rsp_opcode == exp_r.opcode)
          else fail_value("o_rsp_opcode", 32'(o_rsp_opcode), 32'(exp_r.opcode));
        assert (o_rsp_status == exp_r.status)
          else fail_value("o_rsp_status", 32'(o_rsp_status), 32'(exp_r.status));
        assert (o_rsp_data == exp_r.data)
          else fail_value("o_rsp_data", o_rsp_data, exp_r.data);
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      fail_text("timeout, the run did not finish within the cycle limit");
    end
  end

  initial begin
    int          n;
    logic [31:0] r;
    opcode_e     op;
    i_rst_n      <= 1'b0;
    i_cmd_vld    <= 1'b0;
    i_cmd_engid  <= '0;
    i_cmd_opcode <= OP_PUSH;
    i_cmd_data   <= '0;
    i_rsp_rdy    <= 1'b1;
    repeat (4) @(posedge clk);
    i_rst_n <= 1'b1;
    @(negedge clk);
    assert (!o_rsp_vld) else fail_value("o_rsp_vld", 32'(o_rsp_vld), 32'd0);
    assert (!o_cmd_credit) else fail_value("o_cmd_credit", 32'(o_cmd_credit), 32'd0);

    // Fixed latency for a push and a pop
    check_latency(OP_PUSH, 2'd0, rand_bits(32));
    check_latency(OP_POP, 2'd0, '0);

    // LIFO order on one context
    repeat (5) send_cmd(OP_PUSH, 2'd1, rand_bits(32));
    pop_all(2'd1);
    // Just emptied and never used
    send_cmd(OP_POP, 2'd1, '0);
    send_cmd(OP_POP, 2'd3, '0);
    // Errors must not disturb the state
    send_cmd(OP_PUSH, 2'd1, rand_bits(32));
    send_cmd(OP_POP, 2'd1, '0);
    drain();

    // Fill the pool across all contexts
    for (int i = 0; i < `STK_SLOTS_N; i++) begin
      send_cmd(OP_PUSH, i[1:0], rand_bits(32));
    end
    send_cmd(OP_PUSH, 2'd3, rand_bits(32));
    // One slot freed so one push fits before the pool is full again
    send_cmd(OP_POP, 2'd2, '0);
    send_cmd(OP_PUSH, 2'd0, rand_bits(32));
    send_cmd(OP_PUSH, 2'd1, rand_bits(32));
    for (int e = 0; e < `STK_ENGS_N; e++) begin
      pop_all(e[1:0]);
    end
    drain();

    // Push right after a pop takes the slot just released
    send_cmd(OP_PUSH, 2'd0, rand_bits(32));
    send_cmd(OP_POP, 2'd0, '0);
    send_cmd(OP_PUSH, 2'd2, rand_bits(32));
    send_cmd(OP_POP, 2'd2, '0);
    drain();

    // Random mix with pushes weighted 5 of 8
    // Ready low a quarter of the cycles
    n = 0;
    while (n < RAND_CMDS) begin
      @(posedge clk);
      r = rand_bits(2);
      i_rsp_rdy <= (r != 32'd0);
      if (credits_left() > 0 && rand_bits(1) == 32'd1) begin
        r  = rand_bits(3);
        op = (r < 32'd5) ? OP_PUSH : OP_POP;
        r  = rand_bits(2);
        drive_cmd(op, r[1:0], rand_bits(32));
        n++;
      end else begin
        i_cmd_vld <= 1'b0;
      end
    end
    @(posedge clk);
    i_cmd_vld <= 1'b0;
    i_rsp_rdy <= 1'b1;
    for (int e = 0; e < `STK_ENGS_N; e++) begin
      pop_all(e[1:0]);
    end
    drain();

    // Sink stalled until all credits are spent and the queue holds every response
    @(posedge clk);
    i_rsp_rdy <= 1'b0;
    repeat (`STK_CREDITS_N) send_cmd(OP_PUSH, 2'd3, rand_bits(32));
    wait_cycles(12);
    @(negedge clk);
    assert (o_rsp_vld) else fail_value("o_rsp_vld", 32'(o_rsp_vld), 32'd1);
    @(posedge clk);
    i_rsp_rdy <= 1'b1;
    send_cmd(OP_POP, 2'd3, '0);
    send_cmd(OP_POP, 2'd3, '0);
    pop_all(2'd3);
    drain();

    wait_cycles(2);
    @(negedge clk);
    if (exp_q.size() == 0 && !o_rsp_vld) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_text("responses left over at the end of the run");
    end
  end

endmodule : tb_stk_engine

// File: hw/stk_engine.sv
/*
 * Stack engine top level
 *   lookup, context table, slot allocator
 *   data RAM and response queue
 */
`timescale 1ns/1ps

module stk_engine
  import stk_cfg_pkg::*;
  import stk_cmd_pkg::*;
(
  input  logic    clk,
  input  logic    i_rst_n,
  input  logic    i_cmd_vld,
  input  engid_t  i_cmd_engid,
  input  opcode_e i_cmd_opcode,
  input  data_t   i_cmd_data,
  output logic    o_cmd_credit,
  output logic    o_rsp_vld,
  output engid_t  o_rsp_engid,
  output opcode_e o_rsp_opcode,
  output status_e o_rsp_status,
  output data_t   o_rsp_data,
  input  logic    i_rsp_rdy
);

  // Lookup to table and allocator
  logic    ctx_push;
  logic    ctx_pop;
  logic    alloc_take;
  // Table to lookup and allocator
  ptr_t    head_ptr;
  logic    is_empty;
  logic    release_vld;
  ptr_t    release_ptr;
  // Allocator to lookup and table
  ptr_t    free_ptr;
  logic    full;
  // Stage 1 RAM access
  logic    ram_we;
  logic    ram_re;
  ptr_t    ram_addr;
  data_t   ram_wdata;
  data_t   ram_rdata;
  // Stage 1 response fields
  logic    s1_vld;
  engid_t  s1_engid;
  opcode_e s1_opcode;
  status_e s1_status;

  stk_lookup u_lookup (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_vld    (i_cmd_vld),
    .i_cmd_opcode (i_cmd_opcode),
    .i_cmd_engid  (i_cmd_engid),
    .i_cmd_data   (i_cmd_data),
    .i_head_ptr   (head_ptr),
    .i_is_empty   (is_empty),
    .i_full       (full),
    .i_free_ptr   (free_ptr),
    .o_ctx_push   (ctx_push),
    .o_ctx_pop    (ctx_pop),
    .o_alloc_take (alloc_take),
    .o_ram_we     (ram_we),
    .o_ram_re     (ram_re),
    .o_ram_addr   (ram_addr),
    .o_ram_wdata  (ram_wdata),
    .o_s1_vld     (s1_vld),
    .o_s1_engid   (s1_engid),
    .o_s1_opcode  (s1_opcode),
    .o_s1_status  (s1_status)
  );

  // Table is indexed by the incoming command's context
  stk_ctx_table u_ctx_table (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_engid       (i_cmd_engid),
    .i_push        (ctx_push),
    .i_pop         (ctx_pop),
    .i_new_ptr     (free_ptr),
    .o_head_ptr    (head_ptr),
    .o_is_empty    (is_empty),
    .o_release     (release_vld),
    .o_release_ptr (release_ptr)
  );

  stk_slot_alloc u_slot_alloc (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_take        (alloc_take),
    .i_release     (release_vld),
    .i_release_ptr (release_ptr),
    .o_free_ptr    (free_ptr),
    .o_full        (full)
  );

  stk_data_ram u_data_ram (
    .clk     (clk),
    .i_we    (ram_we),
    .i_re    (ram_re),
    .i_addr  (ram_addr),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

  stk_rsp_queue u_rsp_queue (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_s1_vld     (s1_vld),
    .i_s1_engid   (s1_engid),
    .i_s1_opcode  (s1_opcode),
    .i_s1_status  (s1_status),
    .i_ram_rdata  (ram_rdata),
    .i_rsp_rdy    (i_rsp_rdy),
    .o_rsp_vld    (o_rsp_vld),
    .o_rsp_engid  (o_rsp_engid),
    .o_rsp_opcode (o_rsp_opcode),
    .o_rsp_status (o_rsp_status),
    .o_rsp_data   (o_rsp_data),
    .o_cmd_credit (o_cmd_credit)
  );

endmodule : stk_engine

// File: hw/stk_rsp_queue.sv
/*
 * Response path
 *   stage 2 registers aligned with RAM read data
 *   in-order response FIFO, depth equal to the credit count
 *   credit return on each response handshake
 */
`timescale 1ns/1ps

`include "stk_consts.svh"

module stk_rsp_queue
  import stk_cfg_pkg::*;
  import stk_cmd_pkg::*;
(
  input  logic    clk,
  input  logic    i_rst_n,
  input  logic    i_s1_vld,
  input  engid_t  i_s1_engid,
  input  opcode_e i_s1_opcode,
  input  status_e i_s1_status,
  input  data_t   i_ram_rdata,
  input  logic    i_rsp_rdy,
  output logic    o_rsp_vld,
  output engid_t  o_rsp_engid,
  output opcode_e o_rsp_opcode,
  output status_e o_rsp_status,
  output data_t   o_rsp_data,
  output logic    o_cmd_credit
);

  localparam int DEPTH = `STK_CREDITS_N;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  // Stage 2, lines up with the RAM output
  logic    s2_vld;
  engid_t  s2_engid;
  opcode_e s2_opcode;
  status_e s2_status;
  data_t   s2_data;

  // FIFO storage
  engid_t  q_engid  [DEPTH];
  opcode_e q_opcode [DEPTH];
  status_e q_status [DEPTH];
  data_t   q_data   [DEPTH];

  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          q_push;
  logic          q_pop;

  // Stage 2 registers
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s2_vld <= 1'b0;
    end else begin
      s2_vld <= i_s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    s2_engid  <= i_s1_engid;
    s2_opcode <= i_s1_opcode;
    s2_status <= i_s1_status;
  end

  // RAM word only for a good pop
  assign s2_data = ((s2_opcode == OP_POP) && (s2_status == ST_OKAY)) ? i_ram_rdata : '0;

  // Credits keep the FIFO from overflowing
  assign q_push = s2_vld;
  assign q_pop  = o_rsp_vld & i_rsp_rdy;

  // Entry write
  always_ff @(posedge clk) begin
    if (q_push) begin
      q_engid[wr_ptr_q]  <= s2_engid;
      q_opcode[wr_ptr_q] <= s2_opcode;
      q_status[wr_ptr_q] <= s2_status;
      q_data[wr_ptr_q]   <= s2_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (q_push) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (q_pop) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (q_push && !q_pop) begin
        count_q <= count_q + 1'b1;
      end else if (q_pop && !q_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Head of FIFO drives the response port
  assign o_rsp_vld    = (count_q != '0);
  assign o_rsp_engid  = q_engid[rd_ptr_q];
  assign o_rsp_opcode = q_opcode[rd_ptr_q];
  assign o_rsp_status = q_status[rd_ptr_q];
  assign o_rsp_data   = q_data[rd_ptr_q];

  // One credit back per response taken
  assign o_cmd_credit = q_pop;

endmodule : stk_rsp_queue

// File: hw/stk_data_ram.sv
/*
 * Slot data storage
 *   single port, synchronous, read-first
 */
`timescale 1ns/1ps

`include "stk_consts.svh"

module stk_data_ram (
  input  logic                           clk,
  input  logic                           i_we,
  input  logic                           i_re,
  input  logic [$clog2(`STK_SLOTS_N)-1:0] i_addr,
  input  logic [`STK_DATA_W-1:0]         i_wdata,
  output logic [`STK_DATA_W-1:0]         o_rdata
);

  // One word per pool slot
  logic [`STK_DATA_W-1:0] mem_q [`STK_SLOTS_N];

  // Read sees the word held before this cycle's write
  // Output holds between reads
  always_ff @(posedge clk) begin
    if (i_re) begin
      o_rdata <= mem_q[i_addr];
    end
    if (i_we) begin
      mem_q[i_addr] <= i_wdata;
    end
  end

endmodule : stk_data_ram

// File: hw/stk_lookup.sv
/*
 * Lookup stage
 *   opcode decode and status
 *   state update strobes to table and allocator
 *   stage 1 registers for the data access and response fields
 */
`timescale 1ns/1ps

module stk_lookup
  import stk_cfg_pkg::*;
  import stk_cmd_pkg::*;
(
  input  logic    clk,
  input  logic    i_rst_n,
  input  logic    i_cmd_vld,
  input  opcode_e i_cmd_opcode,
  input  engid_t  i_cmd_engid,
  input  data_t   i_cmd_data,
  input  ptr_t    i_head_ptr,
  input  logic    i_is_empty,
  input  logic    i_full,
  input  ptr_t    i_free_ptr,
  output logic    o_ctx_push,
  output logic    o_ctx_pop,
  output logic    o_alloc_take,
  output logic    o_ram_we,
  output logic    o_ram_re,
  output ptr_t    o_ram_addr,
  output data_t   o_ram_wdata,
  output logic    o_s1_vld,
  output engid_t  o_s1_engid,
  output opcode_e o_s1_opcode,
  output status_e o_s1_status
);

  // Decoder
  logic    cmd_is_push;
  logic    cmd_is_pop;
  // Error terms
  logic    pop_from_empty;
  logic    push_to_full;
  logic    status_okay;
  status_e status;

  assign cmd_is_push = i_cmd_vld & (i_cmd_opcode == OP_PUSH);
  assign cmd_is_pop  = i_cmd_vld & (i_cmd_opcode == OP_POP);

  // Nothing to pop
  assign pop_from_empty = cmd_is_pop & i_is_empty;
  // No free slot in the pool
  assign push_to_full   = cmd_is_push & i_full;
  assign status_okay    = ~(pop_from_empty | push_to_full);

  always_comb begin
    status = ST_OKAY;
    if (pop_from_empty) begin
      status = ST_ERR_EMPTY;
    end else if (push_to_full) begin
      status = ST_ERR_FULL;
    end
  end

  // Only good commands touch the state
  assign o_ctx_push   = cmd_is_push & status_okay;
  assign o_ctx_pop    = cmd_is_pop & status_okay;
  assign o_alloc_take = o_ctx_push;

  // Stage 1 control
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_s1_vld <= 1'b0;
      o_ram_we <= 1'b0;
      o_ram_re <= 1'b0;
    end else begin
      o_s1_vld <= i_cmd_vld;
      o_ram_we <= o_ctx_push;
      o_ram_re <= o_ctx_pop;
    end
  end

  // Stage 1 payload
  // Push writes the granted slot, pop reads the current head
  always_ff @(posedge clk) begin
    o_ram_addr  <= cmd_is_push ? i_free_ptr : i_head_ptr;
    o_ram_wdata <= i_cmd_data;
    o_s1_engid  <= i_cmd_engid;
    o_s1_opcode <= i_cmd_opcode;
    o_s1_status <= status;
  end

endmodule : stk_lookup

// File: hw/stk_ctx_table.sv
/*
 * Per-context stack state
 *   head and tail pointer tables, empty bits
 *   link array, each slot points at the slot below it
 *   slot release on pop
 */
`timescale 1ns/1ps

`include "stk_consts.svh"

module stk_ctx_table
  import stk_cfg_pkg::*;
(
  input  logic   clk,
  input  logic   i_rst_n,
  input  engid_t i_engid,
  input  logic   i_push,
  input  logic   i_pop,
  input  ptr_t   i_new_ptr,
  output ptr_t   o_head_ptr,
  output logic   o_is_empty,
  output logic   o_release,
  output ptr_t   o_release_ptr
);

  // Top of stack per context
  ptr_t head_q [`STK_ENGS_N];
  // Bottom of stack per context
  ptr_t tail_q [`STK_ENGS_N];
  // Empty flag per context
  logic [`STK_ENGS_N-1:0] empty_q;
  // Slot below, indexed by slot
  ptr_t link_q [`STK_SLOTS_N];

  // Current context view
  ptr_t head_cur;
  ptr_t tail_cur;
  logic last_entry;

  assign head_cur = head_q[i_engid];
  assign tail_cur = tail_q[i_engid];

  // Single entry left in the stack
  assign last_entry = (head_cur == tail_cur);

  // Lookup reads head and empty against the live state
  assign o_head_ptr = head_cur;
  assign o_is_empty = empty_q[i_engid];

  // Popped head goes back to the allocator in the same cycle
  assign o_release     = i_pop;
  assign o_release_ptr = head_cur;

  // Pointer and empty updates
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      head_q  <= '{default: '0};
      tail_q  <= '{default: '0};
      empty_q <= '1;
    end else begin
      if (i_push) begin
        // New slot becomes the top
        head_q[i_engid] <= i_new_ptr;
        // First entry also marks the bottom
        if (empty_q[i_engid]) begin
          tail_q[i_engid]  <= i_new_ptr;
          empty_q[i_engid] <= 1'b0;
        end
      end else if (i_pop) begin
        // Step down to the slot below
        head_q[i_engid] <= link_q[head_cur];
        // Tail goes stale here, the empty bit guards it
        if (last_entry) begin
          empty_q[i_engid] <= 1'b1;
        end
      end
    end
  end

  // Link of the new slot records the old head
  always_ff @(posedge clk) begin
    if (i_push) begin
      link_q[i_new_ptr] <= head_cur;
    end
  end

endmodule : stk_ctx_table

// File: hw/stk_slot_alloc.sv
/*
 * Slot allocator for the shared pool
 *   free bitmap, lowest free slot offered
 *   take on push, release on pop, both allowed in one cycle
 */
`timescale 1ns/1ps

`include "stk_consts.svh"

module stk_slot_alloc
  import stk_cfg_pkg::*;
(
  input  logic clk,
  input  logic i_rst_n,
  input  logic i_take,
  input  logic i_release,
  input  ptr_t i_release_ptr,
  output ptr_t o_free_ptr,
  output logic o_full
);

  // One bit per slot, set means free
  logic [`STK_SLOTS_N-1:0] free_q;
  logic [`STK_SLOTS_N-1:0] free_nxt;

  // Priority pick of the lowest free slot
  // Scan downward so the last hit is the lowest index
  always_comb begin
    o_free_ptr = '0;
    for (int i = `STK_SLOTS_N - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        o_free_ptr = ptr_t'(i);
      end
    end
  end

  // No free bit left
  assign o_full = ~|free_q;

  // Next bitmap
  // Taken and released slots never collide, a released slot is in use
  always_comb begin
    free_nxt = free_q;
    if (i_take) begin
      free_nxt[o_free_ptr] = 1'b0;
    end
    if (i_release) begin
      free_nxt[i_release_ptr] = 1'b1;
    end
  end

  // All slots free out of reset
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      free_q <= '1;
    end else begin
      free_q <= free_nxt;
    end
  end

endmodule : stk_slot_alloc

// File: hw/stk_cmd_pkg.sv
/*
 * Command and response encodings
 *   opcode_e  push or pop
 *   status_e  okay, pop-from-empty, push-to-full
 */
package stk_cmd_pkg;

  // Command opcodes
  typedef enum logic [0:0] {
    OP_PUSH = 1'b0,
    OP_POP  = 1'b1
  } opcode_e;

  // Response status
  typedef enum logic [1:0] {
    ST_OKAY      = 2'd0,
    ST_ERR_EMPTY = 2'd1,
    ST_ERR_FULL  = 2'd2
  } status_e;

endpackage : stk_cmd_pkg

// File: hw/stk_cfg_pkg.sv
/*
 * Sizing types for the stack engine
 *   ptr_t   slot index into the shared pool
 *   engid_t context id
 *   data_t  stored data word
 */
package stk_cfg_pkg;

`include "stk_consts.svh"

  // Slot index, one per pool entry
  typedef logic [$clog2(`STK_SLOTS_N)-1:0] ptr_t;

  // Context id
  typedef logic [$clog2(`STK_ENGS_N)-1:0] engid_t;

  // Payload word
  typedef logic [`STK_DATA_W-1:0] data_t;

endpackage : stk_cfg_pkg

// File: include/stk_consts.svh
/*
 * Sizing constants for the stack engine
 *   contexts, pool slots, data word width
 *   command credits, which also set the response queue depth
 */
`ifndef STK_CONSTS_SVH
`define STK_CONSTS_SVH

// Number of stack contexts
`define STK_ENGS_N 4

// Shared slot pool size
`define STK_SLOTS_N 16

// Data word width
`define STK_DATA_W 32

// Command credits and response queue depth
`define STK_CREDITS_N 4

`endif
